/* build.f */
+incdir+rtl
rtl/tsp_pkg.sv
rtl/move_pkg.sv
rtl/move_dispatch.sv
rtl/twoopt_move_gen.sv
rtl/move_collect.sv
rtl/move_engine_top.sv
tb/move_engine_checker.sv
tb/move_engine_tb.sv

/* rtl/move_collect.sv */
`timescale 1ns/10ps
`default_nettype none

`include "move_settings.svh"

module move_collect (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic              [`LANE_NUM-1:0]     lane_done_i,
    input  wire logic              [`LANE_NUM-1:0]     lane_op_i,
    input  wire tsp_pkg::base_id_t [`LANE_NUM-1:0]     lane_base_id_i,
    input  wire tsp_pkg::city_t    [`LANE_NUM-1:0]     lane_k_i,
    input  wire tsp_pkg::city_t    [`LANE_NUM-1:0]     lane_l_i,
    input  wire move_pkg::rand_t   [`LANE_NUM-1:0]     lane_r_metropolis_i,
    input  wire move_pkg::rand_t   [`LANE_NUM-1:0]     lane_r_exchange_i,
    output logic                   [`LANE_NUM-1:0]     lane_ack_o,
    output logic                                       res_valid_o,
    input  wire logic                                  res_ready_i,
    output tsp_pkg::opt_cmd_t                          res_op_o,
    output tsp_pkg::base_id_t                          res_base_id_o,
    output tsp_pkg::city_t                             res_k_o,
    output tsp_pkg::city_t                             res_l_o,
    output move_pkg::rand_t                            res_r_metropolis_o,
    output move_pkg::rand_t                            res_r_exchange_o
);

    move_pkg::lane_id_t rd_ptr;
    logic               res_fire;

    // Drain in the same order the dispatcher filled the lanes.
    assign res_valid_o        = lane_done_i[rd_ptr];
    assign res_fire           = res_valid_o && res_ready_i;
    assign res_op_o           = tsp_pkg::opt_cmd_t'(lane_op_i[rd_ptr]);
    assign res_base_id_o      = lane_base_id_i[rd_ptr];
    assign res_k_o            = lane_k_i[rd_ptr];
    assign res_l_o            = lane_l_i[rd_ptr];
    assign res_r_metropolis_o = lane_r_metropolis_i[rd_ptr];
    assign res_r_exchange_o   = lane_r_exchange_i[rd_ptr];

    always_comb begin
        lane_ack_o = '0;
        if (res_fire) begin
            lane_ack_o[rd_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (res_fire) begin
            if (rd_ptr == move_pkg::lane_id_t'(`LANE_NUM - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/move_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "move_settings.svh"

module move_dispatch (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 cmd_valid_i,
    output logic                      cmd_ready_o,
    input  wire logic [`LANE_NUM-1:0] lane_idle_i,
    output logic      [`LANE_NUM-1:0] lane_start_o
);

    move_pkg::lane_id_t wr_ptr;
    logic               cmd_fire;

    // Only the lane under the pointer may take the next command.
    assign cmd_ready_o = lane_idle_i[wr_ptr];
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;

    always_comb begin
        lane_start_o = '0;
        if (cmd_fire) begin
            lane_start_o[wr_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (cmd_fire) begin
            if (wr_ptr == move_pkg::lane_id_t'(`LANE_NUM - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/move_engine_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "move_settings.svh"

module move_engine_top (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               cmd_valid_i,
    input  wire tsp_pkg::opt_cmd_t  cmd_op_i,
    input  wire tsp_pkg::base_id_t  cmd_base_id_i,
    output logic                    cmd_ready_o,
    output logic                    res_valid_o,
    input  wire logic               res_ready_i,
    output tsp_pkg::opt_cmd_t       res_op_o,
    output tsp_pkg::base_id_t       res_base_id_o,
    output tsp_pkg::city_t          res_k_o,
    output tsp_pkg::city_t          res_l_o,
    output move_pkg::rand_t         res_r_metropolis_o,
    output move_pkg::rand_t         res_r_exchange_o
);

    logic              [`LANE_NUM-1:0] lane_idle;
    logic              [`LANE_NUM-1:0] lane_start;
    logic              [`LANE_NUM-1:0] lane_done;
    logic              [`LANE_NUM-1:0] lane_ack;
    logic              [`LANE_NUM-1:0] lane_op;
    tsp_pkg::base_id_t [`LANE_NUM-1:0] lane_base_id;
    tsp_pkg::city_t    [`LANE_NUM-1:0] lane_k;
    tsp_pkg::city_t    [`LANE_NUM-1:0] lane_l;
    move_pkg::rand_t   [`LANE_NUM-1:0] lane_r_metropolis;
    move_pkg::rand_t   [`LANE_NUM-1:0] lane_r_exchange;

    move_dispatch u_move_dispatch (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .lane_idle_i  (lane_idle),
        .lane_start_o (lane_start)
    );

    // Command fields fan out to every lane; only the started one latches.
    for (genvar i = 0; i < `LANE_NUM; i++) begin : g_lane
        twoopt_move_gen #(
            .LANE_ID (i)
        ) u_twoopt_move_gen (
            .clk            (clk),
            .reset          (reset),
            .start_i        (lane_start[i]),
            .op_i           (cmd_op_i),
            .base_id_i      (cmd_base_id_i),
            .ack_i          (lane_ack[i]),
            .idle_o         (lane_idle[i]),
            .done_o         (lane_done[i]),
            .op_o           (lane_op[i]),
            .base_id_o      (lane_base_id[i]),
            .k_o            (lane_k[i]),
            .l_o            (lane_l[i]),
            .r_metropolis_o (lane_r_metropolis[i]),
            .r_exchange_o   (lane_r_exchange[i])
        );
    end

    move_collect u_move_collect (
        .clk                 (clk),
        .reset               (reset),
        .lane_done_i         (lane_done),
        .lane_op_i           (lane_op),
        .lane_base_id_i      (lane_base_id),
        .lane_k_i            (lane_k),
        .lane_l_i            (lane_l),
        .lane_r_metropolis_i (lane_r_metropolis),
        .lane_r_exchange_i   (lane_r_exchange),
        .lane_ack_o          (lane_ack),
        .res_valid_o         (res_valid_o),
        .res_ready_i         (res_ready_i),
        .res_op_o            (res_op_o),
        .res_base_id_o       (res_base_id_o),
        .res_k_o             (res_k_o),
        .res_l_o             (res_l_o),
        .res_r_metropolis_o  (res_r_metropolis_o),
        .res_r_exchange_o    (res_r_exchange_o)
    );

endmodule

`default_nettype wire

/* rtl/move_pkg.sv */
`default_nettype none

`include "move_settings.svh"

package move_pkg;

    typedef logic [31:0] rand_t;
    typedef logic [63:0] xs_state_t;
    typedef logic [$clog2(`LANE_NUM)-1:0] lane_id_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_K,
        S_L,
        S_METROPOLIS,
        S_EXCHANGE,
        S_DONE
    } move_state_t;

endpackage

`default_nettype wire

/* rtl/move_settings.svh */
`ifndef MOVE_SETTINGS_SVH
`define MOVE_SETTINGS_SVH

// Problem size and lane count.
`define CITY_NUM  48
`define LANE_NUM  4
`define BASE_LOG  4

// Lane i seeds with this value plus i plus 1.
`define SEED_BASE 64'h9e37_79b9_7f4a_7c15

`endif

/* rtl/tsp_pkg.sv */
`default_nettype none

`include "move_settings.svh"

package tsp_pkg;

    // City numbers run from 1 to CITY_NUM.
    typedef logic [$clog2(`CITY_NUM + 1)-1:0] city_t;

    typedef logic [`BASE_LOG-1:0] base_id_t;

    typedef enum logic {
        TWO = 1'b0,
        THR = 1'b1
    } opt_cmd_t;

endpackage

`default_nettype wire

/* rtl/twoopt_move_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "move_settings.svh"

module twoopt_move_gen #(
    parameter int LANE_ID = 0
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start_i,
    input  wire tsp_pkg::opt_cmd_t   op_i,
    input  wire tsp_pkg::base_id_t   base_id_i,
    input  wire logic                ack_i,
    output logic                     idle_o,
    output logic                     done_o,
    output tsp_pkg::opt_cmd_t        op_o,
    output tsp_pkg::base_id_t        base_id_o,
    output tsp_pkg::city_t           k_o,
    output tsp_pkg::city_t           l_o,
    output move_pkg::rand_t          r_metropolis_o,
    output move_pkg::rand_t          r_exchange_o
);

    localparam move_pkg::xs_state_t LANE_SEED = `SEED_BASE + 64'(LANE_ID + 1);

    move_pkg::move_state_t state;
    move_pkg::xs_state_t   xs_q;
    move_pkg::xs_state_t   xs_step1;
    move_pkg::xs_state_t   xs_step2;
    move_pkg::xs_state_t   xs_next;
    move_pkg::rand_t       draw;
    tsp_pkg::city_t        draw_city;
    logic                  city_ok;
    logic                  drawing;

    // Xorshift64 step with shifts of 13 left, 7 right and 17 left.
    always_comb begin
        xs_step1  = xs_q ^ (xs_q << 13);
        xs_step2  = xs_step1 ^ (xs_step1 >> 7);
        xs_next   = xs_step2 ^ (xs_step2 << 17);
        draw      = xs_next[31:0];
        draw_city = draw[5:0];
        city_ok   = (draw_city != '0) && (draw_city <= tsp_pkg::city_t'(`CITY_NUM));
    end

    assign drawing = (state == move_pkg::S_K) || (state == move_pkg::S_L) ||
                     (state == move_pkg::S_METROPOLIS) || (state == move_pkg::S_EXCHANGE);

    assign idle_o = (state == move_pkg::S_IDLE);
    assign done_o = (state == move_pkg::S_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            xs_q <= LANE_SEED;
        end else if (drawing) begin
            xs_q <= xs_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= move_pkg::S_IDLE;
            op_o           <= tsp_pkg::TWO;
            base_id_o      <= '0;
            k_o            <= '0;
            l_o            <= '0;
            r_metropolis_o <= '0;
            r_exchange_o   <= '0;
        end else begin
            case (state)
                move_pkg::S_IDLE: begin
                    if (start_i) begin
                        op_o <= op_i;
                        // THR leaves the last move fields untouched.
                        if (op_i == tsp_pkg::THR) begin
                            state <= move_pkg::S_DONE;
                        end else begin
                            base_id_o <= base_id_i;
                            state     <= move_pkg::S_K;
                        end
                    end
                end
                move_pkg::S_K: begin
                    if (city_ok) begin
                        k_o   <= draw_city;
                        state <= move_pkg::S_L;
                    end
                end
                move_pkg::S_L: begin
                    if (city_ok) begin
                        if (draw_city == k_o) begin
                            state <= move_pkg::S_K;
                        end else begin
                            // Keep K below L.
                            if (draw_city < k_o) begin
                                k_o <= draw_city;
                                l_o <= k_o;
                            end else begin
                                l_o <= draw_city;
                            end
                            state <= move_pkg::S_METROPOLIS;
                        end
                    end
                end
                move_pkg::S_METROPOLIS: begin
                    r_metropolis_o <= draw;
                    state          <= move_pkg::S_EXCHANGE;
                end
                move_pkg::S_EXCHANGE: begin
                    r_exchange_o <= draw;
                    state        <= move_pkg::S_DONE;
                end
                move_pkg::S_DONE: begin
                    if (ack_i) begin
                        state <= move_pkg::S_IDLE;
                    end
                end
                default: begin
                    state <= move_pkg::S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the move engine testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f build.f --top-module move_engine_tb -o move_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/move_engine_sim +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb/move_engine_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module move_engine_checker (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              res_valid_i,
    input wire logic              res_ready_i,
    input wire tsp_pkg::opt_cmd_t res_op_i,
    input wire tsp_pkg::base_id_t res_base_id_i,
    input wire tsp_pkg::city_t    res_k_i,
    input wire tsp_pkg::city_t    res_l_i,
    input wire move_pkg::rand_t   res_r_metropolis_i,
    input wire move_pkg::rand_t   res_r_exchange_i
);

    int assert_fail_cnt = 0;

    // A stalled result holds until it is taken.
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (res_valid_i && !res_ready_i) |=>
            (res_valid_i && $stable(res_op_i) && $stable(res_base_id_i) &&
             $stable(res_k_i) && $stable(res_l_i) &&
             $stable(res_r_metropolis_i) && $stable(res_r_exchange_i)))
    else begin
        assert_fail_cnt++;
        $error("Result output changed while stalled");
    end

    valid_after_reset: assert property (@(posedge clk) reset |=> !res_valid_i)
    else begin
        assert_fail_cnt++;
        $error("res_valid_o high in the cycle after reset");
    end

    k_below_l: assert property (@(posedge clk) disable iff (reset)
        (res_valid_i && res_op_i == tsp_pkg::TWO) |-> (res_k_i < res_l_i))
    else begin
        assert_fail_cnt++;
        $error("2-opt result with K not below L");
    end

endmodule

`default_nettype wire

/* tb/move_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "move_settings.svh"

module move_engine_tb;

    localparam int MAX_REC = 64;

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid_i;
    tsp_pkg::opt_cmd_t    cmd_op_i;
    logic [`BASE_LOG-1:0] cmd_base_id_i;
    logic                 cmd_ready_o;
    logic                 res_valid_o;
    logic                 res_ready_i;
    tsp_pkg::opt_cmd_t    res_op_o;
    logic [`BASE_LOG-1:0] res_base_id_o;
    tsp_pkg::city_t       res_k_o;
    tsp_pkg::city_t       res_l_o;
    logic [31:0]          res_r_metropolis_o;
    logic [31:0]          res_r_exchange_o;

    int          rec_op [MAX_REC];
    int          rec_base [MAX_REC];
    int          rec_stall [MAX_REC];
    int          rec_exp_base [MAX_REC];
    logic [31:0] exp_k [MAX_REC];
    logic [31:0] exp_l [MAX_REC];
    logic [31:0] exp_rm [MAX_REC];
    logic [31:0] exp_re [MAX_REC];
    logic [63:0] xs [`LANE_NUM];
    int          n_rec;
    int          stall_sum;
    int          cycle_cnt;
    int          cycle_limit;
    int          in_flight;
    int          ready_err;
    int          tests_pass;
    int          tests_fail;
    int          check_fails;
    bit          lanes_filled;
    bit          ok;

    move_engine_top u_move_engine_top (
        .clk                (clk),
        .reset              (reset),
        .cmd_valid_i        (cmd_valid_i),
        .cmd_op_i           (cmd_op_i),
        .cmd_base_id_i      (cmd_base_id_i),
        .cmd_ready_o        (cmd_ready_o),
        .res_valid_o        (res_valid_o),
        .res_ready_i        (res_ready_i),
        .res_op_o           (res_op_o),
        .res_base_id_o      (res_base_id_o),
        .res_k_o            (res_k_o),
        .res_l_o            (res_l_o),
        .res_r_metropolis_o (res_r_metropolis_o),
        .res_r_exchange_o   (res_r_exchange_o)
    );

    bind move_engine_top move_engine_checker u_move_engine_checker (
        .clk                (clk),
        .reset              (reset),
        .res_valid_i        (res_valid_o),
        .res_ready_i        (res_ready_i),
        .res_op_i           (res_op_o),
        .res_base_id_i      (res_base_id_o),
        .res_k_i            (res_k_o),
        .res_l_i            (res_l_o),
        .res_r_metropolis_i (res_r_metropolis_o),
        .res_r_exchange_i   (res_r_exchange_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Number of busy lanes from accepted commands minus drained results.
    always @(posedge clk) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(cmd_valid_i && cmd_ready_o)
                                   - int'(res_valid_o && res_ready_i);
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (in_flight == `LANE_NUM) begin
                lanes_filled = 1'b1;
            end
            assert (cmd_ready_o == (in_flight < `LANE_NUM)) else begin
                $display("[ERROR] %0t cmd_ready_o expected %0b actual %0b",
                         $time, in_flight < `LANE_NUM, cmd_ready_o);
                ready_err++;
            end
        end
    end

    always @(negedge clk) begin
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 7);
        t = t ^ (t << 17);
        return t;
    endfunction

    function automatic logic [31:0] next_word(input int lane);
        xs[lane] = xorshift64(xs[lane]);
        return xs[lane][31:0];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Rejection sampling of two distinct cities before the two test words.
    task automatic draw_move(input int lane, output logic [31:0] k, output logic [31:0] l,
                             output logic [31:0] rm, output logic [31:0] re);
        logic [31:0] a;
        logic [31:0] b;
        do begin
            do a = next_word(lane) & 32'h3f; while (a == 0 || a > `CITY_NUM);
            do b = next_word(lane) & 32'h3f; while (b == 0 || b > `CITY_NUM);
        end while (a == b);
        k = (a < b) ? a : b;
        l = (a < b) ? b : a;
        rm = next_word(lane);
        re = next_word(lane);
    endtask

    task automatic predict_results();
        logic [31:0] last_k [`LANE_NUM];
        logic [31:0] last_l [`LANE_NUM];
        logic [31:0] last_rm [`LANE_NUM];
        logic [31:0] last_re [`LANE_NUM];
        int          lane;
        for (int i = 0; i < `LANE_NUM; i++) begin
            xs[i] = `SEED_BASE + 64'(i + 1);
            last_k[i] = '0;
            last_l[i] = '0;
            last_rm[i] = '0;
            last_re[i] = '0;
        end
        for (int j = 0; j < n_rec; j++) begin
            lane = j % `LANE_NUM;
            // THR leaves the lane's last move in place.
            if (rec_op[j] == 0) begin
                draw_move(lane, last_k[lane], last_l[lane], last_rm[lane], last_re[lane]);
            end
            exp_k[j] = last_k[lane];
            exp_l[j] = last_l[lane];
            exp_rm[j] = last_rm[lane];
            exp_re[j] = last_re[lane];
        end
    endtask

    task automatic read_patterns();
        int    fd;
        int    op_v;
        int    base_v;
        int    stall_v;
        int    exp_v;
        string line;
        n_rec = 0;
        stall_sum = 0;
        fd = $fopen("tb/move_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/move_patterns.txt");
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%d %h %d %h", op_v, base_v, stall_v, exp_v) == 4) begin
                    rec_op[n_rec] = op_v;
                    rec_base[n_rec] = base_v;
                    rec_stall[n_rec] = stall_v;
                    rec_exp_base[n_rec] = exp_v;
                    stall_sum += stall_v;
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v, inout bit pass_flag);
        assert (exp_v == act_v) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            pass_flag = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit pass_flag);
        $display("Test %s: %s", name, pass_flag ? "pass" : "FAIL");
        if (pass_flag) begin
            tests_pass++;
        end else begin
            tests_fail++;
        end
    endtask

    task automatic drive_commands();
        logic [31:0] lcg;
        lcg = 32'h7b4c;
        for (int i = 0; i < n_rec; i++) begin
            lcg = lcg_next(lcg);
            repeat (int'(lcg[17:16])) @(negedge clk);
            cmd_valid_i = 1'b1;
            cmd_op_i = (rec_op[i] == 1) ? tsp_pkg::THR : tsp_pkg::TWO;
            cmd_base_id_i = `BASE_LOG'(rec_base[i]);
            while (!cmd_ready_o) @(negedge clk);
            @(negedge clk);
            cmd_valid_i = 1'b0;
        end
    endtask

    task automatic drain_results();
        bit good;
        for (int j = 0; j < n_rec; j++) begin
            if (rec_stall[j] > 0) begin
                res_ready_i = 1'b0;
                repeat (rec_stall[j]) @(negedge clk);
            end
            res_ready_i = 1'b1;
            while (!res_valid_o) @(negedge clk);
            good = 1'b1;
            compare_field("res_op_o", rec_op[j], 32'(res_op_o), good);
            compare_field("res_base_id_o", rec_exp_base[j], 32'(res_base_id_o), good);
            compare_field("res_k_o", exp_k[j], 32'(res_k_o), good);
            compare_field("res_l_o", exp_l[j], 32'(res_l_o), good);
            compare_field("res_r_metropolis_o", exp_rm[j], res_r_metropolis_o, good);
            compare_field("res_r_exchange_o", exp_re[j], res_r_exchange_o, good);
            if (rec_op[j] == 0) begin
                assert (res_k_o != 0 && res_k_o < res_l_o && int'(res_l_o) <= `CITY_NUM)
                else begin
                    $display("Move %0d breaks the city range or K below L: K %0d, L %0d",
                             j, res_k_o, res_l_o);
                    good = 1'b0;
                end
            end
            report_test($sformatf("%0d %s lane %0d", j, rec_op[j] == 1 ? "THR" : "TWO",
                                  j % `LANE_NUM), good);
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_op_i = tsp_pkg::TWO;
        cmd_base_id_i = '0;
        res_ready_i = 1'b0;
        tests_pass = 0;
        tests_fail = 0;
        ready_err = 0;
        lanes_filled = 1'b0;
        cycle_limit = 1000;
        read_patterns();
        predict_results();
        cycle_limit = 64 * n_rec + stall_sum + 200;
        ok = 1'b1;
        assert (n_rec > 0) else begin
            $display("No stimulus records were read from the pattern file");
            ok = 1'b0;
        end
        report_test("pattern load", ok);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        ok = 1'b1;
        compare_field("res_valid_o", 32'd0, 32'(res_valid_o), ok);
        compare_field("cmd_ready_o", 32'd1, 32'(cmd_ready_o), ok);
        report_test("reset state", ok);

        fork
            drive_commands();
            drain_results();
        join

        ok = (ready_err == 0);
        assert (lanes_filled) else begin
            $display("Back-pressure never filled all %0d lanes", `LANE_NUM);
            ok = 1'b0;
        end
        report_test("back-pressure", ok);

        check_fails = u_move_engine_top.u_move_engine_checker.assert_fail_cnt;
        $display("Tests passed: %0d, failed: %0d, checker assertion failures: %0d",
                 tests_pass, tests_fail, check_fails);
        if (tests_fail == 0 && check_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/move_patterns.txt */
# op (0 TWO, 1 THR)  base_id (hex)  ready stall cycles  expected base_id (hex)
# K, L and both random words are predicted by the lane model in the testbench.
0 3 0 3
0 a 0 a
1 5 1 0
0 7 0 7
1 2 0 3
0 c 40 c
0 1 0 1
0 f 0 f
0 4 2 4
1 9 0 c
0 6 0 6
1 0 25 f
0 b 0 b
0 8 1 8
1 e 0 6
0 d 3 d
1 3 0 b
0 2 0 2
